// ==== Bender.yml ====
package:
  name: m68k_cache

sources:
  - design/cacheGeometryPkg.sv
  - design/cacheBusPkg.sv
  - design/cacheWayArray.sv
  - design/plruTree.sv
  - design/tagDirectory.sv
  - design/cacheController.sv
  - design/m68kCacheTop.sv
  - target: test
    files:
      - verification/m68kCache_chk.sv
      - verification/m68kCacheTb.sv

// ==== design/cacheBusPkg.sv ====
package cacheBusPkg;

	////////////////////////////////////////////////////////////////////////////
	// controller FSM states
	////////////////////////////////////////////////////////////////////////////
	typedef enum logic [3:0] {
		Reset,											// one cycle after reset is released
		Invalidate,										// clears one set per cycle
		Idle,
		CheckHit,										// directory lookup result is known here
		HitHold,										// cache word on the bus until the cpu ends
		RequestDram,									// select DRAM, wait for a read command
		CasWait,
		BurstFill,										// one word per cycle into the victim way
		MissHold,
		WriteThrough									// DRAM write with forwarded DTACK
	} ctrlStateT;

	////////////////////////////////////////////////////////////////////////////
	// DRAM controller burst timing
	////////////////////////////////////////////////////////////////////////////
	localparam int casLatency  = 2;						// cycles from read command to first word
	localparam int burstLength = cacheGeometryPkg::lineWords;	// a fill is always one full line

endpackage

// ==== design/cacheController.sv ====
`timescale 1ns/100ps

module cacheController import cacheGeometryPkg::*, cacheBusPkg::*; (
	input  logic                 Clock,
	input  logic                 Reset_L,
	// cpu side
	input  logic [addrWidth-1:0] Address,
	input  dataWordT             DataFromCpu,
	input  logic                 As_L,
	input  logic                 Uds_L,
	input  logic                 Lds_L,
	input  logic                 We_L,
	input  logic                 DramSelect,				// cpu address decodes to DRAM
	output dataWordT             DataToCpu,
	output logic                 DtackToCpu_L,
	// DRAM controller side
	input  logic                 DramDtack_L,
	input  logic                 DramCas_L,
	input  logic                 DramRas_L,
	output logic [addrWidth-1:0] DramAddress,
	output dataWordT             DataToDram,
	output logic                 DramSelect_L,
	output logic                 DramAs_L,
	output logic                 DramWe_L,
	output logic                 DramUds_L,
	output logic                 DramLds_L,
	// directory
	input  logic [numWays-1:0]   hitWays,
	input  plruT                 plruBits,
	output setIdxT               setIdx,
	output logic [numWays-1:0]   writeWays,
	output logic                 writeValid,
	output logic                 invalidateAll,
	output logic                 plruWrite,
	output plruT                 plruNext,
	// data array
	input  dataWordT             dataWays [numWays],
	output logic [numWays-1:0]   dataWrWay,
	output wordIdxT              dataWordIdx
);

	ctrlStateT          state;
	ctrlStateT          nextState;
	setIdxT             count;								// invalidate set, CAS wait or burst word
	wayIdxT             victimReg;							// way being refilled on a miss
	wayIdxT             victimWay;
	wayIdxT             hitIdx;
	wayIdxT             touchWay;
	logic [numWays-1:0] victimMask;
	logic               cpuActive;

	assign cpuActive  = !As_L && DramSelect;				// cpu is running a DRAM cycle
	assign victimMask = {{(numWays-1){1'b0}}, 1'b1} << victimReg;
	assign DataToDram = DataFromCpu;						// only sampled by DRAM on a write
	assign DramAs_L   = As_L;

	// at most one way can hit, so a priority encode gives its number
	always_comb begin
		hitIdx = '0;
		for (int w = 0; w < numWays; w++) begin
			if (hitWays[w]) begin
				hitIdx = wayIdxT'(w);
			end
		end
	end

	// a hit refreshes the way that hit, a miss refreshes the victim
	assign touchWay = (|hitWays) ? hitIdx : victimWay;

	plruTree plru (
		.treeBits  (plruBits),
		.touchWay  (touchWay),
		.victimWay (victimWay),
		.nextBits  (plruNext)
	);

	// hit states read the hit way, miss hold reads the freshly filled one
	assign DataToCpu = dataWays[(state == MissHold) ? victimReg : hitIdx];

	////////////////////////////////////////////////////////////////////////////
	// state, counter and victim registers
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			state     <= Reset;
			count     <= '0;
			victimReg <= '0;
		end else begin
			state <= nextState;
			count <= (nextState != state) ? '0 : count + 1'b1;	// restarts in each new state
			if (state == CheckHit && !(|hitWays)) begin
				victimReg <= victimWay;						// held for the whole refill
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// next state and outputs
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		nextState     = state;
		DtackToCpu_L  = 1'b1;
		DramSelect_L  = 1'b1;
		DramAddress   = {Address[addrWidth-1:setLsb], {setLsb{1'b0}}};	// line aligned
		DramWe_L      = 1'b1;
		DramUds_L     = 1'b1;
		DramLds_L     = 1'b1;
		setIdx        = Address[setLsb +: setIdxWidth];
		writeWays     = '0;
		writeValid    = 1'b0;
		invalidateAll = 1'b0;
		plruWrite     = 1'b0;
		dataWrWay     = '0;
		dataWordIdx   = Address[wordLsb +: wordIdxWidth];
		unique case (state)
			Reset: nextState = Invalidate;
			Invalidate: begin
				setIdx        = count;						// walks sets 0 to 127
				invalidateAll = 1'b1;
				if (count == setIdxT'(numSets - 1)) nextState = Idle;
			end
			Idle: begin
				if (cpuActive && We_L) begin
					nextState = CheckHit;
				end else if (cpuActive) begin
					writeWays = hitWays;					// drop any stale copy of the line
					nextState = WriteThrough;
				end
			end
			CheckHit: begin
				plruWrite = 1'b1;
				if (|hitWays) begin
					DtackToCpu_L = 1'b0;					// data is already valid this cycle
					nextState    = HitHold;
				end else begin
					nextState = RequestDram;
				end
			end
			HitHold: begin
				DtackToCpu_L = !cpuActive;
				if (!cpuActive) nextState = Idle;
			end
			RequestDram: begin
				DramSelect_L = 1'b0;
				DramUds_L    = 1'b0;						// a fill always reads both bytes
				DramLds_L    = 1'b0;
				writeWays    = victimMask;					// claim the victim for the new tag
				writeValid   = 1'b1;
				// CAS with RAS low is a refresh and must not start the count
				if (!DramCas_L && DramRas_L) nextState = CasWait;
			end
			CasWait: begin
				DramSelect_L = 1'b0;
				DramUds_L    = 1'b0;
				DramLds_L    = 1'b0;
				if (count == setIdxT'(casLatency - 1)) nextState = BurstFill;
			end
			BurstFill: begin
				DramSelect_L = 1'b0;
				DramUds_L    = 1'b0;
				DramLds_L    = 1'b0;
				dataWrWay    = victimMask;
				dataWordIdx  = count[wordIdxWidth-1:0];	// word k arrives in the k-th cycle
				if (count == setIdxT'(burstLength - 1)) nextState = MissHold;
			end
			MissHold: begin
				DtackToCpu_L = !cpuActive;
				if (!cpuActive) nextState = Idle;
			end
			WriteThrough: begin
				DramSelect_L = 1'b0;
				DramAddress  = Address;						// full address for a single write
				DramWe_L     = 1'b0;
				DramUds_L    = Uds_L;
				DramLds_L    = Lds_L;
				DtackToCpu_L = DramDtack_L || !cpuActive;	// DRAM decides when the write ends
				if (!cpuActive) nextState = Idle;
			end
			default: nextState = Reset;
		endcase
	end

endmodule

// ==== design/cacheGeometryPkg.sv ====
package cacheGeometryPkg;

	////////////////////////////////////////////////////////////////////////////
	// bus widths and cache shape
	////////////////////////////////////////////////////////////////////////////
	localparam int addrWidth    = 32;						// byte address from the 68000
	localparam int dataWidth    = 16;						// one bus word
	localparam int numWays      = 8;						// ways per set
	localparam int wayIdxWidth  = $clog2(numWays);
	localparam int numSets      = 128;
	localparam int setIdxWidth  = $clog2(numSets);
	localparam int lineWords    = 8;						// sixteen-bit words per cache line
	localparam int wordIdxWidth = $clog2(lineWords);
	localparam int plruWidth    = numWays - 1;				// one bit per inner node of the tree

	////////////////////////////////////////////////////////////////////////////
	// address fields, bit 0 is the byte lane and never reaches the cache
	////////////////////////////////////////////////////////////////////////////
	localparam int wordLsb  = 1;							// word in line sits at bits 3 to 1
	localparam int setLsb   = wordLsb + wordIdxWidth;		// set index sits at bits 10 to 4
	localparam int tagLsb   = setLsb + setIdxWidth;		// tag is everything above the set
	localparam int tagWidth = addrWidth - tagLsb;

	typedef logic [tagWidth-1:0]     tagT;
	typedef logic [setIdxWidth-1:0]  setIdxT;
	typedef logic [wordIdxWidth-1:0] wordIdxT;
	typedef logic [wayIdxWidth-1:0]  wayIdxT;
	typedef logic [plruWidth-1:0]    plruT;
	typedef logic [dataWidth-1:0]    dataWordT;

	typedef struct packed {
		logic valid;										// line holds data from DRAM
		tagT  tag;
	} tagEntryT;

endpackage

// ==== design/cacheWayArray.sv ====
`timescale 1ns/100ps

module cacheWayArray import cacheGeometryPkg::*; #(
	parameter type entryT = logic,							// what one way holds at one index
	parameter int  depth  = numSets,
	localparam int idxWidth = $clog2(depth)
) (
	input  logic                Clock,
	input  logic [numWays-1:0]  wrWay,					// one write enable per way
	input  logic [idxWidth-1:0] wrIdx,
	input  entryT               wrData,					// same value goes to every enabled way
	input  logic [idxWidth-1:0] rdIdx,
	output entryT               rdWays [numWays]			// all ways at rdIdx, no clock needed
);

	////////////////////////////////////////////////////////////////////////////
	// one storage array per way
	////////////////////////////////////////////////////////////////////////////
	for (genvar w = 0; w < numWays; w++) begin : gWay
		entryT mem [depth];								// contents are undefined until written

		always_ff @(posedge Clock) begin
			if (wrWay[w]) begin
				mem[wrIdx] <= wrData;					// write lands at the end of the cycle
			end
		end

		// asynchronous read so the lookup result is ready in the same cycle
		assign rdWays[w] = mem[rdIdx];
	end

endmodule

// ==== design/m68kCacheTop.sv ====
`timescale 1ns/100ps

module m68kCacheTop import cacheGeometryPkg::*; (
	input  logic                 Clock,
	input  logic                 Reset_L,
	// cpu side
	input  logic [addrWidth-1:0] Address,
	input  dataWordT             DataFromCpu,
	input  logic                 As_L,
	input  logic                 Uds_L,
	input  logic                 Lds_L,
	input  logic                 We_L,
	input  logic                 DramSelect,
	output dataWordT             DataToCpu,
	output logic                 DtackToCpu_L,
	// DRAM controller side
	input  dataWordT             DataFromDram,
	input  logic                 DramDtack_L,
	input  logic                 DramCas_L,
	input  logic                 DramRas_L,
	output logic [addrWidth-1:0] DramAddress,
	output dataWordT             DataToDram,
	output logic                 DramSelect_L,
	output logic                 DramAs_L,
	output logic                 DramWe_L,
	output logic                 DramUds_L,
	output logic                 DramLds_L
);

	setIdxT             setIdx;
	logic [numWays-1:0] writeWays;
	logic               writeValid;
	logic               invalidateAll;
	logic               plruWrite;
	plruT               plruNext;
	logic [numWays-1:0] hitWays;
	plruT               plruBits;
	logic [numWays-1:0] dataWrWay;
	wordIdxT            dataWordIdx;
	dataWordT           dataWays [numWays];

	tagDirectory directory (
		.Clock         (Clock),
		.Reset_L       (Reset_L),
		.setIdx        (setIdx),
		.lookupTag     (Address[addrWidth-1:tagLsb]),
		.writeWays     (writeWays),
		.writeValid    (writeValid),
		.invalidateAll (invalidateAll),
		.plruWrite     (plruWrite),
		.plruNext      (plruNext),
		.hitWays       (hitWays),
		.plruBits      (plruBits)
	);

	// data words are addressed by set and word, DRAM fills them directly
	cacheWayArray #(.entryT(dataWordT), .depth(numSets * lineWords)) dataArray (
		.Clock  (Clock),
		.wrWay  (dataWrWay),
		.wrIdx  ({setIdx, dataWordIdx}),
		.wrData (DataFromDram),
		.rdIdx  ({setIdx, dataWordIdx}),
		.rdWays (dataWays)
	);

	cacheController controller (.*);

endmodule

// ==== design/plruTree.sv ====
`timescale 1ns/100ps

module plruTree import cacheGeometryPkg::*; (
	input  plruT   treeBits,								// current tree state of the set
	input  wayIdxT touchWay,								// way being used in this access
	output wayIdxT victimWay,								// way the tree points at now
	output plruT   nextBits									// tree state after touchWay is used
);

	////////////////////////////////////////////////////////////////////////////
	// tree layout
	//   bit 0       picks ways 0-3 or ways 4-7
	//   bits 1, 2   pick the pair within the lower or the upper half
	//   bits 3 - 6  pick within pairs 0/1, 2/3, 4/5, 6/7
	// a zero points at the lower numbered side everywhere
	////////////////////////////////////////////////////////////////////////////

	logic       upperHalf;									// root decision
	logic       pairSel;									// decision inside the chosen half
	logic       leafSel;									// decision inside the chosen pair
	logic [1:0] pairIdx;									// which of the four pairs was reached

	// walk from the root down, each level picks one more bit of the way number
	always_comb begin
		upperHalf = treeBits[0];
		pairSel   = upperHalf ? treeBits[2] : treeBits[1];
		pairIdx   = {upperHalf, pairSel};
		leafSel   = treeBits[3 + pairIdx];
		victimWay = {upperHalf, pairSel, leafSel};
	end

	// every node on the touched way's path is turned to face away from it
	always_comb begin
		nextBits                                = treeBits;	// the other four nodes keep their value
		nextBits[0]                             = ~touchWay[2];
		nextBits[1 + touchWay[2]]               = ~touchWay[1];
		nextBits[3 + touchWay[wayIdxWidth-1:1]] = ~touchWay[0];
	end

endmodule

// ==== design/tagDirectory.sv ====
`timescale 1ns/100ps

module tagDirectory import cacheGeometryPkg::*; (
	input  logic               Clock,
	input  logic               Reset_L,
	input  setIdxT             setIdx,					// set being looked up or written
	input  tagT                lookupTag,					// tag field of the cpu address
	input  logic [numWays-1:0] writeWays,				// ways whose entry is rewritten
	input  logic               writeValid,				// valid bit stored with lookupTag
	input  logic               invalidateAll,				// clear the whole set this cycle
	input  logic               plruWrite,					// store plruNext for the set
	input  plruT               plruNext,
	output logic [numWays-1:0] hitWays,					// valid entries whose tag matches
	output plruT               plruBits					// tree bits of the set
);

	tagEntryT           tagWays [numWays];					// every way's entry at setIdx
	tagEntryT           tagWrData;
	logic [numWays-1:0] tagWrWay;
	plruT               plruMem [numSets];					// tree bits, one word per set

	////////////////////////////////////////////////////////////////////////////
	// tag and valid storage
	////////////////////////////////////////////////////////////////////////////

	// invalidation writes a zero entry into all eight ways at once
	always_comb begin
		tagWrWay  = invalidateAll ? '1 : writeWays;
		tagWrData = '0;
		if (!invalidateAll) begin
			tagWrData.valid = writeValid;
			tagWrData.tag   = lookupTag;
		end
	end

	cacheWayArray #(.entryT(tagEntryT), .depth(numSets)) tagArray (
		.Clock  (Clock),
		.wrWay  (tagWrWay),
		.wrIdx  (setIdx),
		.wrData (tagWrData),
		.rdIdx  (setIdx),
		.rdWays (tagWays)
	);

	// a way hits only when its entry is valid and the stored tag matches
	for (genvar w = 0; w < numWays; w++) begin : gHit
		assign hitWays[w] = tagWays[w].valid && (tagWays[w].tag == lookupTag);
	end

	////////////////////////////////////////////////////////////////////////////
	// replacement tree bits
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			plruMem <= '{default: '0};					// every tree starts pointing at way 0
		end else if (invalidateAll) begin
			plruMem[setIdx] <= '0;
		end else if (plruWrite) begin
			plruMem[setIdx] <= plruNext;
		end
	end

	assign plruBits = plruMem[setIdx];

endmodule

// ==== files.f ====
design/cacheGeometryPkg.sv
design/cacheBusPkg.sv
design/cacheWayArray.sv
design/plruTree.sv
design/tagDirectory.sv
design/cacheController.sv
design/m68kCacheTop.sv
verification/m68kCache_chk.sv
verification/m68kCacheTb.sv

// ==== verification/m68kCacheTb.sv ====
`timescale 1ns/100ps

module m68kCacheTb import cacheGeometryPkg::*, cacheBusPkg::*; ();

	localparam int     dtackLimit   = 100;					// cycles any handshake may take
	localparam int     shadowBits   = 16;					// DRAM model decodes address bits 16 to 1
	localparam int     hitDtackEdge = 2;					// idle samples at the next edge and CheckHit answers
	localparam setIdxT conflictSet  = 5;					// set that receives nine different tags

	typedef struct packed {
		logic                 write;
		logic [1:0]           strobes;						// {Uds_L, Lds_L} of a write, reads use both bytes
		logic [addrWidth-1:0] addr;
		dataWordT             data;
		logic                 hit;							// row should be served from the cache
	} rowT;

	logic Clock, Reset_L, As_L, Uds_L, Lds_L, We_L, DramSelect, DtackToCpu_L;
	logic DramDtack_L, DramCas_L, DramRas_L, DramSelect_L;
	logic DramAs_L, DramWe_L, DramUds_L, DramLds_L;
	logic [addrWidth-1:0] Address, DramAddress;
	dataWordT             DataFromCpu, DataToCpu, DataFromDram, DataToDram;

	rowT      stimRows [$];
	dataWordT shadowMem [1 << shadowBits];					// contents of the DRAM behind the cache
	tagT      modelTag [numSets][numWays];					// reference copy of the directory
	logic     modelValid [numSets][numWays];
	plruT     modelTree [numSets];
	int       seed = 83775;
	int       valueErrors = 0, otherErrors = 0, dramErrors = 0;
	int       writeCount = 0, fillCount = 0;
	logic     timedOut = 1'b0, dramStuck = 1'b0;
	logic [addrWidth-1:0] wrAddr;							// last write seen by the DRAM model
	dataWordT             wrData;
	logic [1:0]           wrStrobes;

	m68kCacheTop DUT (.*);

	bind m68kCacheTop m68kCache_chk chk (.*);

	always #5 Clock = ~Clock;

	////////////////////////////////////////////////////////////////////////////
	// reference model of the directory and the replacement tree
	////////////////////////////////////////////////////////////////////////////
	function automatic int wordIndex(input logic [addrWidth-1:0] a);
		return int'(a[shadowBits:1]);
	endfunction

	// nodes sit in heap order so the children of node n are 2n+1 and 2n+2
	function automatic wayIdxT pickVictim(input plruT bits);
		int     node;
		wayIdxT way;
		node = 0;
		way  = '0;
		for (int level = 0; level < wayIdxWidth; level++) begin
			way  = {way[wayIdxWidth-2:0], bits[node]};		// zero follows the lower numbered child
			node = 2 * node + 1 + int'(bits[node]);
		end
		return way;
	endfunction

	function automatic plruT touchTree(input plruT bits, input wayIdxT way);
		int node;
		node = 0;
		for (int level = wayIdxWidth - 1; level >= 0; level--) begin
			bits[node] = ~way[level];						// turn the node away from the used way
			node       = 2 * node + 1 + int'(way[level]);
		end
		return bits;
	endfunction

	function automatic logic predictRead(input logic [addrWidth-1:0] a);
		setIdxT s;
		wayIdxT way;
		logic   hit;
		s   = a[setLsb +: setIdxWidth];
		hit = 1'b0;
		way = pickVictim(modelTree[s]);
		for (int w = 0; w < numWays; w++) begin
			if (modelValid[s][w] && modelTag[s][w] == a[addrWidth-1:tagLsb]) begin
				hit = 1'b1;
				way = wayIdxT'(w);
			end
		end
		modelTag[s][way]   = a[addrWidth-1:tagLsb];			// a miss refills the victim
		modelValid[s][way] = 1'b1;
		modelTree[s]       = touchTree(modelTree[s], way);
		return hit;
	endfunction

	function automatic void dropWrittenLine(input logic [addrWidth-1:0] a);
		setIdxT s;
		s = a[setLsb +: setIdxWidth];
		for (int w = 0; w < numWays; w++) begin
			if (modelTag[s][w] == a[addrWidth-1:tagLsb]) modelValid[s][w] = 1'b0;
		end
	endfunction

	task automatic reportMismatch(input string name, input logic [addrWidth-1:0] actual,
			input logic [addrWidth-1:0] expected);
		$display("Fail at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
		valueErrors++;
	endtask

	task automatic reportProblem(input string what);
		$display("Error at %0t: %s", $time, what);
		otherErrors++;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// cpu bus cycle
	////////////////////////////////////////////////////////////////////////////
	task automatic cpuAccess(input rowT row, input int rowNum);
		int       cycles;
		int       writesBefore;
		logic     sawSelect;
		logic     predicted;
		dataWordT expData;
		if (row.write) begin
			dropWrittenLine(row.addr);
		end else begin
			predicted = predictRead(row.addr);
			assert (predicted == row.hit)
				else reportProblem($sformatf("row %0d hit flag disagrees with the tree model",
					rowNum));
		end
		writesBefore = writeCount;
		@(posedge Clock);
		Address     <= row.addr;
		DataFromCpu <= row.data;
		We_L        <= !row.write;
		Uds_L       <= row.write ? row.strobes[1] : 1'b0;
		Lds_L       <= row.write ? row.strobes[0] : 1'b0;
		As_L        <= 1'b0;
		DramSelect  <= 1'b1;
		cycles      = 0;
		sawSelect   = 1'b0;
		do begin
			@(negedge Clock);
			cycles++;
			sawSelect |= !DramSelect_L;						// a read that selects DRAM is a miss
		end while (DtackToCpu_L && cycles < dtackLimit);
		if (DtackToCpu_L) begin
			reportProblem($sformatf("no DTACK for row %0d within %0d cycles", rowNum, dtackLimit));
			timedOut = 1'b1;
		end else if (row.write) begin
			assert (writeCount == writesBefore + 1)
				else reportProblem($sformatf("write of row %0d never reached DRAM", rowNum));
			// the cpu may only see DTACK once DRAM has acknowledged the write
			assert (!DramDtack_L) else reportMismatch("DramDtack_L", DramDtack_L, 1'b0);
			assert (wrAddr == row.addr) else reportMismatch("DramAddress", wrAddr, row.addr);
			assert (wrData == row.data) else reportMismatch("DataToDram", wrData, row.data);
			assert (wrStrobes == row.strobes)
				else reportMismatch("DramUds_L/DramLds_L", wrStrobes, row.strobes);
		end else begin
			expData = shadowMem[wordIndex(row.addr)];
			assert (DataToCpu == expData) else reportMismatch("DataToCpu", DataToCpu, expData);
			assert (!sawSelect == row.hit)
				else reportProblem($sformatf("row %0d was served %s, expected %s", rowNum,
					sawSelect ? "from DRAM" : "from the cache", row.hit ? "a hit" : "a miss"));
			if (row.hit) begin
				assert (cycles == hitDtackEdge)
					else reportMismatch("DtackToCpu_L delay", cycles, hitDtackEdge);
			end
		end
		@(posedge Clock);
		As_L <= 1'b1;										// ends the bus cycle
	endtask

	////////////////////////////////////////////////////////////////////////////
	// DRAM controller model
	////////////////////////////////////////////////////////////////////////////
	initial begin : dramModel
		int                   delay;
		int                   guard;
		logic [addrWidth-1:0] lineAddr;
		DataFromDram = '0;
		DramDtack_L  = 1'b1;
		DramCas_L    = 1'b1;
		DramRas_L    = 1'b1;
		for (int i = 0; i < (1 << shadowBits); i++) shadowMem[i] = dataWordT'($random(seed));
		forever begin
			@(negedge Clock);
			if (!DramSelect_L && !DramWe_L) begin
				wrAddr    = DramAddress;
				wrData    = DataToDram;
				wrStrobes = {DramUds_L, DramLds_L};
				writeCount++;
				assert (!DramAs_L) else reportMismatch("DramAs_L", DramAs_L, 1'b0);
				if (!DramUds_L) shadowMem[wordIndex(DramAddress)][15:8] = DataToDram[15:8];
				if (!DramLds_L) shadowMem[wordIndex(DramAddress)][7:0] = DataToDram[7:0];
				delay = $random(seed) & 3;
				repeat (delay) @(posedge Clock);
				@(posedge Clock);
				DramDtack_L <= 1'b0;
				guard = 0;
				do begin
					@(negedge Clock);
					guard++;
				end while (!DramAs_L && guard < dtackLimit);
				if (!DramAs_L) begin
					$display("Error at %0t: address strobe never rose after the DRAM write", $time);
					dramErrors++;
					dramStuck = 1'b1;
				end
				@(posedge Clock);
				DramDtack_L <= 1'b1;
			end else if (!DramSelect_L) begin
				lineAddr = DramAddress;
				assert ({DramUds_L, DramLds_L} == 2'b00)	// a fill reads both bytes
					else reportMismatch("DramUds_L/DramLds_L", {DramUds_L, DramLds_L}, 2'b00);
				if (fillCount % 3 == 0) begin				// CAS and RAS low together is a refresh
					@(posedge Clock);
					DramCas_L <= 1'b0;
					DramRas_L <= 1'b0;
					@(posedge Clock);
					DramCas_L <= 1'b1;
					DramRas_L <= 1'b1;
				end
				fillCount++;
				delay = $random(seed) & 3;
				repeat (delay) @(posedge Clock);
				@(posedge Clock);
				DramCas_L <= 1'b0;							// read command with RAS high
				@(posedge Clock);
				DramCas_L <= 1'b1;
				repeat (casLatency) @(posedge Clock);
				for (int k = 0; k < burstLength; k++) begin	// word k lands latency plus one plus k later
					DataFromDram <= shadowMem[wordIndex(lineAddr) + k];
					@(posedge Clock);
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus table and main flow
	////////////////////////////////////////////////////////////////////////////
	initial begin : mainFlow
		logic [addrWidth-1:0] conflictAddr;
		Clock       = 1'b0;
		Reset_L     = 1'b0;
		Address     = '0;
		DataFromCpu = '0;
		As_L        = 1'b1;
		Uds_L       = 1'b1;
		Lds_L       = 1'b1;
		We_L        = 1'b1;
		DramSelect  = 1'b0;
		for (int s = 0; s < numSets; s++) begin
			modelTree[s] = '0;
			for (int w = 0; w < numWays; w++) modelValid[s][w] = 1'b0;
		end
		// write, strobes, address, data, expected hit
		stimRows.push_back({1'b0, 2'b00, 32'h0000_0052, 16'h0000, 1'b0});	// first fill of set 5
		stimRows.push_back({1'b0, 2'b00, 32'h0000_005e, 16'h0000, 1'b1});
		stimRows.push_back({1'b0, 2'b00, 32'h0000_0100, 16'h0000, 1'b0});
		stimRows.push_back({1'b1, 2'b00, 32'h0000_0104, 16'hbeef, 1'b0});	// hits and kills the line
		stimRows.push_back({1'b0, 2'b00, 32'h0000_0104, 16'h0000, 1'b0});
		stimRows.push_back({1'b0, 2'b00, 32'h0000_010a, 16'h0000, 1'b1});
		stimRows.push_back({1'b1, 2'b01, 32'h0000_0106, 16'ha55a, 1'b0});	// upper byte only
		stimRows.push_back({1'b0, 2'b00, 32'h0000_0106, 16'h0000, 1'b0});
		// eight more tags in set 5 and the ninth evicts tag 0
		for (int pass = 0; pass < 2; pass++) begin
			for (int t = 1; t <= numWays; t++) begin
				conflictAddr = (t << tagLsb) | (conflictSet << setLsb)
					| (((t + pass) % lineWords) << wordLsb);
				stimRows.push_back({1'b0, 2'b00, conflictAddr, 16'h0000, pass == 1});
			end
		end
		stimRows.push_back({1'b0, 2'b00, 32'h0000_0058, 16'h0000, 1'b0});	// tag 0 was the victim
		repeat (8) @(posedge Clock);
		Reset_L <= 1'b1;
		repeat (1 + numSets) @(posedge Clock);				// reset state then one set per cycle
		foreach (stimRows[i]) begin
			if (!timedOut && !dramStuck) cpuAccess(stimRows[i], i);
		end
		repeat (2) @(posedge Clock);
		$display("errors: %0d wrong values, %0d other failures, %0d in the DRAM model, %0d bound",
			valueErrors, otherErrors, dramErrors, DUT.chk.failures);
		if (valueErrors == 0 && otherErrors == 0 && dramErrors == 0
				&& DUT.chk.failures == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// ==== verification/m68kCache_chk.sv ====
`timescale 1ns/100ps

module m68kCache_chk import cacheGeometryPkg::*; (
	input logic                 Clock,
	input logic                 Reset_L,
	input logic                 As_L,
	input logic                 DtackToCpu_L,
	input logic                 DramSelect_L,
	input logic                 DramWe_L,
	input logic [addrWidth-1:0] DramAddress
);

	localparam int quietCycles = 1 + numSets;				// reset state plus one cycle per set

	int unsigned cyclesSinceReset;
	int unsigned failures = 0;								// assertion failures seen so far

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			cyclesSinceReset <= 0;
		end else if (cyclesSinceReset < quietCycles) begin
			cyclesSinceReset <= cyclesSinceReset + 1;		// stops counting once invalidation is over
		end
	end

	// DTACK has to follow the address strobe back up within one cycle
	dtackRelease: assert property (@(posedge Clock) disable iff (!Reset_L)
		(As_L && !DtackToCpu_L) |=> !(As_L && !DtackToCpu_L))
		else begin
			$error("DTACK to the cpu stayed low after the address strobe rose");
			failures++;
		end

	noEarlySelect: assert property (@(posedge Clock) disable iff (!Reset_L)
		(cyclesSinceReset < quietCycles) |-> DramSelect_L)
		else begin
			$error("DRAM was selected during the invalidation period");
			failures++;
		end

	// a line fill always starts at word 0 of the line
	lineAlignedFill: assert property (@(posedge Clock) disable iff (!Reset_L)
		(!DramSelect_L && DramWe_L) |-> (DramAddress[setLsb-1:0] == '0))
		else begin
			$error("line fill address is not aligned to a cache line");
			failures++;
		end

endmodule
